/* design/arena_cfg.svh */
// Field bounds, object size, speeds, home positions and scan-code width
`ifndef ARENA_CFG_SVH
`define ARENA_CFG_SVH

// Playfield bounds in pixels, VGA 640x480
`define ARENA_X_MIN 10'd0
`define ARENA_X_MAX 10'd639
`define ARENA_Y_MIN 10'd0
`define ARENA_Y_MAX 10'd479

// Every square is 2*OBJ_HALF wide
`define OBJ_HALF 10'd16

// Pixels per frame
`define PLAYER_STEP 10'd1   // Keyboard-driven square
`define OBS_STEP 10'd2      // Obstacles after first bounce

// Player start point, left side of the field
`define PLAYER_HOME_X 10'd30
`define PLAYER_HOME_Y 10'd240

// Obstacle A starts low and left
`define OBS_A_HOME_X 10'd150
`define OBS_A_HOME_Y 10'd350

// Obstacle B starts at field centre
`define OBS_B_HOME_X 10'd320
`define OBS_B_HOME_Y 10'd240

// Keyboard scan code width
`define KEY_W 8

`endif

/* design/arenaPkg.sv */
// Scan-code constants and the edge-bounce velocity function
`include "arena_cfg.svh"

package arenaPkg;

    // USB HID usage codes for the steering keys
    localparam logic [`KEY_W-1:0] keyUp    = 8'h1A;   // W
    localparam logic [`KEY_W-1:0] keyDown  = 8'h16;   // S
    localparam logic [`KEY_W-1:0] keyLeft  = 8'h04;   // A
    localparam logic [`KEY_W-1:0] keyRight = 8'h07;   // D
    localparam logic [`KEY_W-1:0] keyNone  = 8'h00;   // Key released

    // Velocity after edge check on one axis
    // Velocities are 10-bit two's complement
    function automatic logic [9:0] bounceVel
    (
        input logic [9:0] pos,
        input logic [9:0] vel,
        input logic [9:0] half,
        input logic [9:0] lo,
        input logic [9:0] hi,
        input logic [9:0] step
    );
        logic [9:0] result;
        result = vel;                           // Default keep direction
        if ((pos + half) >= hi)
        begin
            result = 10'd0 - step;              // Far edge, head back
        end
        else if (pos <= (lo + half))            // Same as pos-half <= lo, no wrap
        begin
            result = step;                      // Near edge, head out
        end
        return result;
    endfunction

endpackage

/* design/keyLatch.sv */
// Four-phase req/ack receiver that holds the last accepted scan code
`timescale 1ns/1ps
`include "arena_cfg.svh"

module keyLatch
(
    input  logic              frame_clk,
    input  logic              arstN,
    input  logic              keyReq,     // Host request with code valid while high
    input  logic [`KEY_W-1:0] keyCode,
    output logic              keyAck,
    output logic [`KEY_W-1:0] heldKey     // Code steering the player
);

    // Two states only with keyAck itself as the state bit
    // Idle (ack low) waits for req and Acked (ack high) waits for req to drop

    logic takeCode;     // Request seen while idle
    logic releaseAck;   // Host done so return to idle

    assign takeCode   = keyReq && !keyAck;
    assign releaseAck = !keyReq && keyAck;

    always_ff @(posedge frame_clk or negedge arstN)
    begin
        if (!arstN)
        begin
            keyAck  <= 1'b0;
            heldKey <= arenaPkg::keyNone;   // Player parked until first key
        end
        else if (takeCode)
        begin
            keyAck  <= 1'b1;                // One cycle after req rises
            heldKey <= keyCode;             // Captured together with ack
        end
        else if (releaseAck)
        begin
            keyAck <= 1'b0;                 // One cycle after req falls
        end
    end

    // Ack only answers a live request
    ackRiseNeedsReq: assert property
    (
        @(posedge frame_clk) disable iff (!arstN)
        $rose(keyAck) |-> $past(keyReq)
    )
    else $error("keyAck rose without keyReq");

    // Ack holds until host withdraws
    ackFallNeedsNoReq: assert property
    (
        @(posedge frame_clk) disable iff (!arstN)
        $fell(keyAck) |-> !$past(keyReq)
    )
    else $error("keyAck fell while keyReq high");

endmodule

/* design/playerMover.sv */
// Player square: key decode, edge bounce and position update
`timescale 1ns/1ps
`include "arena_cfg.svh"

module playerMover
(
    input  logic              frame_clk,
    input  logic              arstN,
    input  logic [`KEY_W-1:0] heldKey,
    input  logic              hit,        // Registered collision, send home
    output logic [9:0]        playerX,
    output logic [9:0]        playerY
);

    logic [9:0] velX;       // Two's complement pixels per frame
    logic [9:0] velY;
    logic [9:0] velXKey;    // After key decode
    logic [9:0] velYKey;
    logic [9:0] velXNext;   // After bounce
    logic [9:0] velYNext;

    // Key decode, one axis at a time
    always_comb
    begin
        velXKey = velX;     // Unknown code keeps direction
        velYKey = velY;
        case (heldKey)
            arenaPkg::keyUp:
            begin
                velXKey = 10'd0;
                velYKey = 10'd0 - `PLAYER_STEP;     // Screen Y grows downward
            end
            arenaPkg::keyDown:
            begin
                velXKey = 10'd0;
                velYKey = `PLAYER_STEP;
            end
            arenaPkg::keyLeft:
            begin
                velXKey = 10'd0 - `PLAYER_STEP;
                velYKey = 10'd0;
            end
            arenaPkg::keyRight:
            begin
                velXKey = `PLAYER_STEP;
                velYKey = 10'd0;
            end
            default:
            begin
                velXKey = velX;
                velYKey = velY;
            end
        endcase

        // Edges override the key
        velXNext = arenaPkg::bounceVel(playerX, velXKey, `OBJ_HALF,
                                       `ARENA_X_MIN, `ARENA_X_MAX, `PLAYER_STEP);
        velYNext = arenaPkg::bounceVel(playerY, velYKey, `OBJ_HALF,
                                       `ARENA_Y_MIN, `ARENA_Y_MAX, `PLAYER_STEP);
    end

    always_ff @(posedge frame_clk or negedge arstN)
    begin
        if (!arstN)
        begin
            playerX <= `PLAYER_HOME_X;
            playerY <= `PLAYER_HOME_Y;
            velX    <= 10'd0;
            velY    <= 10'd0;
        end
        else if (hit)
        begin
            playerX <= `PLAYER_HOME_X;      // Collision restart, standing still
            playerY <= `PLAYER_HOME_Y;
            velX    <= 10'd0;
            velY    <= 10'd0;
        end
        else if (heldKey == arenaPkg::keyNone)
        begin
            velX <= 10'd0;                  // Released, hold position
            velY <= 10'd0;
        end
        else
        begin
            velX    <= velXNext;
            velY    <= velYNext;
            playerX <= playerX + velXNext;  // Moves with the new velocity
            playerY <= playerY + velYNext;
        end
    end

    // Bounce keeps the square on screen, wrap would show as huge value
    playerInField: assert property
    (
        @(posedge frame_clk) disable iff (!arstN)
        (10'(playerX - `ARENA_X_MIN) <= 10'(`ARENA_X_MAX - `ARENA_X_MIN)) &&
        (10'(playerY - `ARENA_Y_MIN) <= 10'(`ARENA_Y_MAX - `ARENA_Y_MIN))
    )
    else $error("player left the field at (%0d,%0d)", playerX, playerY);

endmodule

/* design/obstacleMover.sv */
// Free-bouncing obstacle square with its own home state
`timescale 1ns/1ps
`include "arena_cfg.svh"

module obstacleMover
#(
    parameter logic [9:0] homeX    = 10'd320,
    parameter logic [9:0] homeY    = 10'd240,
    parameter logic [9:0] homeVelX = 10'd1,    // Slow start, OBS_STEP after bounce
    parameter logic [9:0] homeVelY = 10'd0
)
(
    input  logic       frame_clk,
    input  logic       arstN,
    input  logic       hit,
    output logic [9:0] obsX,
    output logic [9:0] obsY
);

    logic [9:0] velX;
    logic [9:0] velY;
    logic [9:0] velXNext;
    logic [9:0] velYNext;

    // No steering, only the walls change direction
    assign velXNext = arenaPkg::bounceVel(obsX, velX, `OBJ_HALF,
                                          `ARENA_X_MIN, `ARENA_X_MAX, `OBS_STEP);
    assign velYNext = arenaPkg::bounceVel(obsY, velY, `OBJ_HALF,
                                          `ARENA_Y_MIN, `ARENA_Y_MAX, `OBS_STEP);

    always_ff @(posedge frame_clk or negedge arstN)
    begin
        if (!arstN)
        begin
            obsX <= homeX;
            obsY <= homeY;
            velX <= homeVelX;
            velY <= homeVelY;
        end
        else if (hit)
        begin
            obsX <= homeX;          // Restart with the player
            obsY <= homeY;
            velX <= homeVelX;
            velY <= homeVelY;
        end
        else
        begin
            velX <= velXNext;
            velY <= velYNext;
            obsX <= obsX + velXNext;
            obsY <= obsY + velYNext;
        end
    end

    // Speed bound per axis, both signs
    obsSpeedLimit: assert property
    (
        @(posedge frame_clk) disable iff (!arstN)
        ((velX <= `OBS_STEP) || (10'(10'd0 - velX) <= `OBS_STEP)) &&
        ((velY <= `OBS_STEP) || (10'(10'd0 - velY) <= `OBS_STEP))
    )
    else $error("obstacle velocity out of range (%0h,%0h)", velX, velY);

endmodule

/* design/hitDetect.sv */
// Box-overlap test of the player against both obstacles, registered hit
`timescale 1ns/1ps
`include "arena_cfg.svh"

module hitDetect
(
    input  logic       frame_clk,
    input  logic       arstN,
    input  logic [9:0] playerX,
    input  logic [9:0] playerY,
    input  logic [9:0] obsAX,
    input  logic [9:0] obsAY,
    input  logic [9:0] obsBX,
    input  logic [9:0] obsBY,
    output logic       hit
);

    // Centre spacing at which squares meet
    localparam logic [9:0] touchDist = `OBJ_HALF + `OBJ_HALF;

    logic       overlapA;
    logic       overlapB;

    // Unsigned distance between two coordinates
    function automatic logic [9:0] absDiff(input logic [9:0] a, input logic [9:0] b);
        logic [9:0] d;
        d = (a >= b) ? (a - b) : (b - a);
        return d;
    endfunction

    // Both axes must be close for a touch
    assign overlapA = (absDiff(playerX, obsAX) < touchDist) &&
                      (absDiff(playerY, obsAY) < touchDist);
    assign overlapB = (absDiff(playerX, obsBX) < touchDist) &&
                      (absDiff(playerY, obsBY) < touchDist);

    always_ff @(posedge frame_clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hit <= 1'b0;
        end
        else
        begin
            hit <= overlapA || overlapB;    // Movers react on the next edge
        end
    end

endmodule

/* design/arenaTop.sv */
// Game engine top: key latch, player, two obstacles and hit detector
`timescale 1ns/1ps
`include "arena_cfg.svh"

module arenaTop
(
    input  logic              frame_clk,
    input  logic              arstN,
    input  logic              keyReq,
    input  logic [`KEY_W-1:0] keyCode,
    output logic              keyAck,
    output logic [9:0]        playerX,
    output logic [9:0]        playerY,
    output logic [9:0]        obsAX,
    output logic [9:0]        obsAY,
    output logic [9:0]        obsBX,
    output logic [9:0]        obsBY,
    output logic              hit
);

    logic [`KEY_W-1:0] heldKey;     // Latch to player

    // Input side
    keyLatch keyLatchInst (
        .frame_clk (frame_clk),
        .arstN     (arstN),
        .keyReq    (keyReq),
        .keyCode   (keyCode),
        .keyAck    (keyAck),
        .heldKey   (heldKey)
    );

    playerMover playerInst (
        .frame_clk (frame_clk),
        .arstN     (arstN),
        .heldKey   (heldKey),
        .hit       (hit),
        .playerX   (playerX),
        .playerY   (playerY)
    );

    // Drifts right first
    obstacleMover #(
        .homeX    (`OBS_A_HOME_X),
        .homeY    (`OBS_A_HOME_Y),
        .homeVelX (10'd1),
        .homeVelY (10'd0)
    ) obsA (
        .frame_clk (frame_clk),
        .arstN     (arstN),
        .hit       (hit),
        .obsX      (obsAX),
        .obsY      (obsAY)
    );

    // Drifts down first
    obstacleMover #(
        .homeX    (`OBS_B_HOME_X),
        .homeY    (`OBS_B_HOME_Y),
        .homeVelX (10'd0),
        .homeVelY (10'd1)
    ) obsB (
        .frame_clk (frame_clk),
        .arstN     (arstN),
        .hit       (hit),
        .obsX      (obsBX),
        .obsY      (obsBY)
    );

    // Output side, hit fans back to all movers
    hitDetect hitInst (
        .frame_clk (frame_clk),
        .arstN     (arstN),
        .playerX   (playerX),
        .playerY   (playerY),
        .obsAX     (obsAX),
        .obsAY     (obsAY),
        .obsBX     (obsBX),
        .obsBY     (obsBY),
        .hit       (hit)
    );

endmodule

/* tb/frameClock.sv */
// Testbench clock source and power-on reset
`timescale 1ns/1ps

module frameClock
(
    output logic frame_clk,
    output logic arstN
);

    initial
    begin
        frame_clk = 1'b0;
        arstN     = 1'b0;                   // Low for two rising edges
        repeat (2) @(posedge frame_clk);
        arstN <= 1'b1;
    end

    always #5 frame_clk = ~frame_clk;       // 10 ns period, one frame per cycle

endmodule

/* tb/arenaTb.sv */
// Arena testbench: stimulus table, reference model, watchdog and reporting
`timescale 1ns/1ps
`include "arena_cfg.svh"

module arenaTb;

    localparam int rows   = 12;
    localparam int kMove  = 0;              // Handshake, then hold key for N frames
    localparam int kChase = 1;              // Steer into obstacle B until hit
    localparam int kEdge  = 2;              // Expect a turn at the left wall
    localparam int half   = int'(`OBJ_HALF);
    localparam int pStep  = int'(`PLAYER_STEP);
    localparam int oStep  = int'(`OBS_STEP);
    localparam int xMin   = int'(`ARENA_X_MIN);
    localparam int xMax   = int'(`ARENA_X_MAX);
    localparam int yMin   = int'(`ARENA_Y_MIN);
    localparam int yMax   = int'(`ARENA_Y_MAX);
    // Index 0 player, 1 obstacle A, 2 obstacle B
    localparam int homeX [3] = '{int'(`PLAYER_HOME_X), int'(`OBS_A_HOME_X),
                                 int'(`OBS_B_HOME_X)};
    localparam int homeY [3] = '{int'(`PLAYER_HOME_Y), int'(`OBS_A_HOME_Y),
                                 int'(`OBS_B_HOME_Y)};
    localparam int homeVX [3] = '{0, 1, 0};  // A drifts right
    localparam int homeVY [3] = '{0, 0, 1};  // B drifts down

    logic       frame_clk;
    logic       arstN;
    logic       keyReq;
    logic [7:0] keyCode;
    logic       keyAck;
    logic       hit;
    logic [9:0] playerX, playerY, obsAX, obsAY, obsBX, obsBY;

    // Reference model state
    int         posX [3];
    int         posY [3];
    int         velX [3];
    int         velY [3];
    bit         mReq, mAck, mHit;           // Host request as seen by DUT, latch, hit
    logic [7:0] mCode, mHeld;

    logic [7:0] keyTab [rows];
    int         frameTab [rows];
    int         kindTab [rows];
    int         errors, hitCount, passCount, failCount, budgetNs, rowStart;
    bit         lastHit, lastHit2, turnSeen, tableReady;
    logic [9:0] lastPX;

    frameClock clockGen (.frame_clk(frame_clk), .arstN(arstN));

    arenaTop uut (.*);

    task automatic setRow(input int r, input logic [7:0] key, input int frames, input int kind);
        keyTab[r]   = key;
        frameTab[r] = frames;
        kindTab[r]  = kind;
    endtask

    task automatic checkVal(input string name, input logic [9:0] got, input logic [9:0] want);
        if (got !== want)
        begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic reportFault(input string what);
        $display("At %0t ns: %s", $time, what);
        errors++;
    endtask

    // Wall rule on one axis, far wall first
    function automatic int wallTurn(input int pos, input int vel, input int lo, input int hi,
                                    input int step);
        if (pos + half >= hi)
            return -step;
        if (pos - half <= lo)
            return step;
        return vel;
    endfunction

    // Player against obstacle i, closer than one square width on both axes
    function automatic bit touching(input int i);
        int dx;
        int dy;
        dx = posX[0] - posX[i];
        dy = posY[0] - posY[i];
        return (dx < 2 * half) && (-dx < 2 * half) && (dy < 2 * half) && (-dy < 2 * half);
    endfunction

    // One rising edge of the whole engine, all from the old state
    task automatic modelEdge();
        int nX [3];
        int nY [3];
        int nVX [3];
        int nVY [3];
        int keyVX;
        int keyVY;
        bit nHit;
        nHit = touching(1) || touching(2);
        for (int i = 0; i < 3; i++)
        begin
            keyVX = velX[i];                // Unknown code keeps direction
            keyVY = velY[i];
            if (i == 0 && (mHeld == arenaPkg::keyUp || mHeld == arenaPkg::keyDown))
            begin
                keyVX = 0;
                keyVY = (mHeld == arenaPkg::keyUp) ? -pStep : pStep;   // Y grows down
            end
            else if (i == 0 && (mHeld == arenaPkg::keyLeft || mHeld == arenaPkg::keyRight))
            begin
                keyVX = (mHeld == arenaPkg::keyLeft) ? -pStep : pStep;
                keyVY = 0;
            end
            nVX[i] = wallTurn(posX[i], keyVX, xMin, xMax, (i == 0) ? pStep : oStep);
            nVY[i] = wallTurn(posY[i], keyVY, yMin, yMax, (i == 0) ? pStep : oStep);
            nX[i]  = posX[i] + nVX[i];
            nY[i]  = posY[i] + nVY[i];
            if (i == 0 && mHeld == arenaPkg::keyNone)
            begin
                nVX[i] = 0;                 // Released, stand still
                nVY[i] = 0;
                nX[i]  = posX[i];
                nY[i]  = posY[i];
            end
            if (mHit)
            begin
                nX[i]  = homeX[i];          // Collision restart
                nY[i]  = homeY[i];
                nVX[i] = homeVX[i];
                nVY[i] = homeVY[i];
            end
        end
        posX = nX;
        posY = nY;
        velX = nVX;
        velY = nVY;
        mHit = nHit;
        if (mReq && !mAck)
        begin
            mAck  = 1'b1;
            mHeld = mCode;
        end
        else if (!mReq && mAck)
            mAck = 1'b0;
    endtask

    task automatic compareAll();
        checkVal("playerX", playerX, 10'(posX[0]));
        checkVal("playerY", playerY, 10'(posY[0]));
        checkVal("obsAX", obsAX, 10'(posX[1]));
        checkVal("obsAY", obsAY, 10'(posY[1]));
        checkVal("obsBX", obsBX, 10'(posX[2]));
        checkVal("obsBY", obsBY, 10'(posY[2]));
        checkVal("hit", {9'd0, hit}, {9'd0, mHit});
        checkVal("keyAck", {9'd0, keyAck}, {9'd0, mAck});
        if (lastHit)                        // Edge after hit loads every home
        begin
            checkVal("playerX", playerX, `PLAYER_HOME_X);
            checkVal("playerY", playerY, `PLAYER_HOME_Y);
            checkVal("obsAX", obsAX, `OBS_A_HOME_X);
            checkVal("obsAY", obsAY, `OBS_A_HOME_Y);
            checkVal("obsBX", obsBX, `OBS_B_HOME_X);
            checkVal("obsBY", obsBY, `OBS_B_HOME_Y);
        end
        if (lastHit2 && hit !== 1'b0)
            reportFault("hit stayed high after the objects returned home");
        if (lastPX == 10'(xMin + half) && playerX == 10'(xMin + half + 1))
            turnSeen = 1'b1;                // Reversed at the left wall
        if (hit === 1'b1 && !lastHit)
            hitCount++;
        lastHit2 = lastHit;
        lastHit  = hit;
        lastPX   = playerX;
    endtask

    // Drive on the rising edge, check at the falling edge
    task automatic runFrame(input logic req, input logic [7:0] code);
        @(posedge frame_clk);
        keyReq  <= req;
        keyCode <= code;
        modelEdge();
        mReq  = req;
        mCode = code;
        @(negedge frame_clk);
        compareAll();
    endtask

    task automatic keyHandshake(input logic [7:0] code, input bit checkMove);
        logic [9:0] x0;
        x0 = playerX;
        runFrame(1'b1, code);               // Request goes up
        if (keyAck !== 1'b0)
            reportFault("keyAck rose on the same edge as keyReq");
        runFrame(1'b1, code);
        if (keyAck !== 1'b1)
            reportFault("keyAck did not rise one cycle after keyReq");
        if (checkMove && playerX !== x0)
            reportFault("player moved before the key was latched");
        runFrame(1'b0, code);               // Request withdrawn
        if (checkMove && playerX === x0)
            reportFault("player did not move two cycles after keyReq");
        runFrame(1'b0, code);
        if (keyAck !== 1'b0)
            reportFault("keyAck did not fall one cycle after keyReq dropped");
    endtask

    task automatic chaseObstacle(input int limit);
        int n;
        int hitsBefore;
        n          = 0;
        hitsBefore = hitCount;
        keyHandshake(arenaPkg::keyRight, 1'b0);
        while (hitCount == hitsBefore && posX[0] < homeX[2] && n < limit)
        begin
            runFrame(1'b0, arenaPkg::keyRight);
            n++;
        end
        if (hitCount == hitsBefore)
            keyHandshake(arenaPkg::keyNone, 1'b0);   // Park in B's column, B sweeps past
        while (hitCount == hitsBefore && n < limit)
        begin
            runFrame(1'b0, arenaPkg::keyNone);
            n++;
        end
        if (hitCount == hitsBefore)
            reportFault("player never touched an obstacle");
        repeat (2) runFrame(1'b0, keyCode);  // Return home, then hit drops
    endtask

    initial
    begin
        keyReq  = 1'b0;
        keyCode = arenaPkg::keyNone;
        void'($urandom(33420));
        setRow(0, arenaPkg::keyRight, 20, kMove);   // Also move latency
        setRow(1, arenaPkg::keyDown, 15, kMove);
        setRow(2, arenaPkg::keyLeft, 15, kMove);
        setRow(3, arenaPkg::keyUp, 15, kMove);
        setRow(4, 8'h55, 15, kMove);                // Unknown, keeps going up
        setRow(5, arenaPkg::keyNone, 15, kMove);    // Parked
        setRow(6, arenaPkg::keyNone, 20 + int'($urandom % 80), kMove);
        setRow(7, arenaPkg::keyDown, 10, kMove);
        setRow(8, arenaPkg::keyNone, 20 + int'($urandom % 80), kMove);
        setRow(9, arenaPkg::keyRight, 1200, kChase);
        setRow(10, arenaPkg::keyLeft, 50, kEdge);
        setRow(11, arenaPkg::keyNone, 20 + int'($urandom % 80), kMove);
        budgetNs = 0;
        for (int r = 0; r < rows; r++)
            budgetNs += frameTab[r] + 4;
        budgetNs   = (budgetNs + 12) * 2 * 10;      // Extra handshake, return, reset
        tableReady = 1'b1;
        posX  = homeX;
        posY  = homeY;
        velX  = homeVX;
        velY  = homeVY;
        mHeld = arenaPkg::keyNone;
        mCode = arenaPkg::keyNone;
        wait (arstN === 1'b1);
        @(negedge frame_clk);
        compareAll();
        $display("Reset check: %s", (errors == 0) ? "pass" : "fail");
        for (int r = 0; r < rows; r++)
        begin
            rowStart = errors;
            turnSeen = 1'b0;
            if (kindTab[r] == kChase)
                chaseObstacle(frameTab[r]);
            else
            begin
                keyHandshake(keyTab[r], r == 0);
                repeat (frameTab[r]) runFrame(1'b0, keyTab[r]);
            end
            if (kindTab[r] == kEdge && !turnSeen)
                reportFault("player did not turn at the left wall");
            if (errors == rowStart)
                passCount++;
            else
                failCount++;
            $display("Row %0d key %02h frames %0d: %s", r, keyTab[r], frameTab[r],
                     (errors == rowStart) ? "pass" : "fail");
        end
        $display("Rows passed %0d, rows failed %0d, errors %0d", passCount, failCount, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog sized from the table
    initial
    begin
        wait (tableReady);
        #(budgetNs);
        $display("Watchdog expired before the stimulus table finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* arenaTop.f */
+incdir+design
design/arenaPkg.sv
design/keyLatch.sv
design/playerMover.sv
design/obstacleMover.sv
design/hitDetect.sv
design/arenaTop.sv
tb/frameClock.sv
tb/arenaTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= arenaTb
FILELIST  ?= arenaTop.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
